// File: frame_defines.svh
`ifndef FRAME_DEFINES_SVH
`define FRAME_DEFINES_SVH

////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////

// pixels per row
`define FRAME_WIDTH 320
// rows per frame
`define FRAME_HEIGHT 240

////////////////////////////////////////////////////////////
// datapath and flow control
////////////////////////////////////////////////////////////

// integral entry width, 320x240 pixels of grey 17 fit in 21 bits
`define INT_BITS 24
// beats the sink can take before its first credit comes back
`define OUT_CREDITS 4

`endif

// File: pixel_pkg.sv
package pixel_pkg;

	////////////////////////////////////////////////////////////
	// input pixel side
	////////////////////////////////////////////////////////////

	// one RGB332 colour pixel, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// grey value, sum of the three colour fields
	// max 7 + 7 + 3, so 8 bits leave plenty of room
	typedef logic [7:0] grey_t;

	// one beat of the camera stream
	// no ready, the source cannot stall
	typedef struct packed {
		logic    valid;
		logic    sof;
		rgb332_t pixel;
	} pixel_beat_t;

endpackage

// File: integral_pkg.sv
`include "frame_defines.svh"

package integral_pkg;

	////////////////////////////////////////////////////////////
	// memory addressing
	////////////////////////////////////////////////////////////

	// entries per frame, one per pixel
	localparam int FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;
	localparam int ADDR_BITS = $clog2(FRAME_PIXELS);

	// raster address, row * width + col
	typedef logic [ADDR_BITS-1:0] frame_addr_t;

	////////////////////////////////////////////////////////////
	// integral values and output stream
	////////////////////////////////////////////////////////////

	// unsigned sum over the rectangle up to (row, col)
	typedef logic [`INT_BITS-1:0] integral_t;

	// output beat, last marks the final entry of a frame
	typedef struct packed {
		logic      valid;
		logic      last;
		integral_t value;
	} int_beat_t;

endpackage

// File: frame_capture.sv
`timescale 1ns/100ps

module frame_capture import pixel_pkg::*, integral_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        readout_done,
	input  pixel_beat_t pix_in,
	output logic        src_we,
	output frame_addr_t src_waddr,
	output grey_t       src_wdata,
	output logic        capture_done,
	output logic        busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ARMED,
		ST_CAPTURE,
		ST_BUSY
	} state_t;

	localparam frame_addr_t LAST_ADDR = frame_addr_t'(FRAME_PIXELS - 1);

	state_t      state;
	frame_addr_t addr_cnt;
	logic        take;
	logic        take_last;
	logic        wr_last;
	grey_t       grey;

	// beat goes into the frame: first sof while armed, then every valid one
	// a sof mid-frame is just another pixel
	assign take = pix_in.valid &&
		((state == ST_ARMED && pix_in.sof) || state == ST_CAPTURE);
	assign take_last = take && (addr_cnt == LAST_ADDR);

	// grey = r + g + b, fields zero extended
	assign grey = grey_t'(pix_in.pixel.red) + grey_t'(pix_in.pixel.green) +
		grey_t'(pix_in.pixel.blue);

	// high from arm until the readout finishes
	assign busy = (state != ST_IDLE);

	////////////////////////////////////////////////////////////
	// frame state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (start) state <= ST_ARMED;
				ST_ARMED: begin
					if (take_last) state <= ST_BUSY;
					else if (take) state <= ST_CAPTURE;
				end
				ST_CAPTURE: if (take_last) state <= ST_BUSY;
				// compute and readout run here, start is ignored
				default: if (readout_done) state <= ST_IDLE;
			endcase
		end
	end

	// write strobe, then done one cycle after the last write
	always_ff @(posedge clk) begin
		if (reset) begin
			src_we <= 1'b0;
			wr_last <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			src_we <= take;
			wr_last <= take_last;
			capture_done <= wr_last;
		end
	end

	////////////////////////////////////////////////////////////
	// raster address and write data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// counter sits at zero until the frame starts
		if (state == ST_IDLE) addr_cnt <= '0;
		else if (take) addr_cnt <= addr_cnt + 1'b1;
		src_waddr <= addr_cnt;
		src_wdata <= grey;
	end

endmodule

// File: frame_ram.sv
`timescale 1ns/100ps

module frame_ram #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  logic [WIDTH-1:0]         wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]         rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// one write port, one registered read port
	// read during write of the same address gives the old word
	always_ff @(posedge clk) begin
		if (we) mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

// File: integral_engine.sv
`timescale 1ns/100ps
`include "frame_defines.svh"

module integral_engine import pixel_pkg::*, integral_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        capture_done,
	output frame_addr_t src_raddr,
	input  grey_t       src_rdata,
	output logic        int_we,
	output frame_addr_t int_waddr,
	output integral_t   int_wdata,
	output logic        compute_done
);

	localparam int COL_BITS = $clog2(`FRAME_WIDTH);
	localparam int ROW_BITS = $clog2(`FRAME_HEIGHT);
	localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`FRAME_WIDTH - 1);
	localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`FRAME_HEIGHT - 1);

	// travels with a read until its data comes back
	typedef struct packed {
		logic                last;
		logic                row0;
		logic [COL_BITS-1:0] col;
		frame_addr_t         addr;
	} tag_t;

	logic                running;
	logic [COL_BITS-1:0] col;
	logic [ROW_BITS-1:0] row;
	logic                at_end;
	logic                tag_valid;
	tag_t                tag;
	integral_t           row_sum;
	integral_t           row_sum_next;
	integral_t           above;
	integral_t           result;
	// integral of the row above, one entry per column
	integral_t           line_buf [`FRAME_WIDTH];

	assign at_end = (col == LAST_COL) && (row == LAST_ROW);

	////////////////////////////////////////////////////////////
	// read stage, one source read per cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) running <= 1'b0;
		else if (!running) running <= capture_done;
		else if (at_end) running <= 1'b0;
	end

	// walk counters rest at zero while idle
	always_ff @(posedge clk) begin
		if (!running) begin
			col <= '0;
			row <= '0;
			src_raddr <= '0;
		end else begin
			src_raddr <= src_raddr + 1'b1;
			if (col == LAST_COL) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
		tag <= '{last: at_end, row0: (row == '0), col: col, addr: src_raddr};
	end

	////////////////////////////////////////////////////////////
	// add stage, data is back one cycle after the read
	////////////////////////////////////////////////////////////

	// row sum restarts at column 0, row 0 has nothing above
	assign row_sum_next = ((tag.col == '0) ? '0 : row_sum) + integral_t'(src_rdata);
	assign above = tag.row0 ? '0 : line_buf[tag.col];
	assign result = row_sum_next + above;

	always_ff @(posedge clk) begin
		if (tag_valid) begin
			row_sum <= row_sum_next;
			line_buf[tag.col] <= result;
			int_waddr <= tag.addr;
			int_wdata <= result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tag_valid <= 1'b0;
			int_we <= 1'b0;
			compute_done <= 1'b0;
		end else begin
			tag_valid <= running;
			int_we <= tag_valid;
			// lines up with the final write, two cycles after the last read
			compute_done <= tag_valid && tag.last;
		end
	end

endmodule

// File: integral_readout.sv
`timescale 1ns/100ps
`include "frame_defines.svh"

module integral_readout import integral_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        compute_done,
	input  logic        credit_return,
	output frame_addr_t int_raddr,
	input  integral_t   int_rdata,
	output int_beat_t   int_out,
	output logic        readout_done
);

	// headroom for credits that come back late
	localparam int CREDIT_BITS = $clog2(2 * `OUT_CREDITS + 1);
	localparam logic [CREDIT_BITS-1:0] FULL_CREDITS = CREDIT_BITS'(`OUT_CREDITS);
	localparam frame_addr_t LAST_ADDR = frame_addr_t'(FRAME_PIXELS - 1);

	logic                   active;
	logic [CREDIT_BITS-1:0] credits;
	logic                   issue;
	logic                   issue_last;
	logic                   beat_valid;
	logic                   beat_last;

	// a read only goes out against a credit
	assign issue = active && (credits != '0);
	assign issue_last = issue && (int_raddr == LAST_ADDR);

	////////////////////////////////////////////////////////////
	// credit and read control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			credits <= FULL_CREDITS;
			beat_valid <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			if (compute_done) active <= 1'b1;
			else if (issue_last) active <= 1'b0;
			// full credit again once the frame is out
			if (readout_done) begin
				credits <= FULL_CREDITS;
			end else begin
				credits <= credits + CREDIT_BITS'(credit_return) - CREDIT_BITS'(issue);
			end
			// flags wait one cycle for the memory data
			beat_valid <= issue;
			beat_last <= issue_last;
		end
	end

	// address walks in raster order, parked at zero between frames
	always_ff @(posedge clk) begin
		if (!active) int_raddr <= '0;
		else if (issue) int_raddr <= int_raddr + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// output beat
	////////////////////////////////////////////////////////////

	assign int_out = '{valid: beat_valid, last: beat_last, value: int_rdata};

	// same cycle as the last beat
	assign readout_done = beat_valid && beat_last;

endmodule

// File: integral_image_top.sv
`timescale 1ns/100ps

module integral_image_top import pixel_pkg::*, integral_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  pixel_beat_t pix_in,
	input  logic        credit_return,
	output int_beat_t   int_out,
	output logic        busy
);

	// source memory side
	logic        src_we;
	frame_addr_t src_waddr;
	grey_t       src_wdata;
	frame_addr_t src_raddr;
	grey_t       src_rdata;

	// integral memory side
	logic        int_we;
	frame_addr_t int_waddr;
	integral_t   int_wdata;
	frame_addr_t int_raddr;
	integral_t   int_rdata;

	// phase handoff
	logic        capture_done;
	logic        compute_done;
	logic        readout_done;

	////////////////////////////////////////////////////////////
	// capture, grey pixels into the source memory
	////////////////////////////////////////////////////////////

	frame_capture frame_capture_i (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.readout_done (readout_done),
		.pix_in       (pix_in),
		.src_we       (src_we),
		.src_waddr    (src_waddr),
		.src_wdata    (src_wdata),
		.capture_done (capture_done),
		.busy         (busy)
	);

	frame_ram #(
		.WIDTH ($bits(grey_t)),
		.DEPTH (FRAME_PIXELS)
	) src_ram_i (
		.clk   (clk),
		.we    (src_we),
		.waddr (src_waddr),
		.wdata (src_wdata),
		.raddr (src_raddr),
		.rdata (src_rdata)
	);

	////////////////////////////////////////////////////////////
	// compute and readout
	////////////////////////////////////////////////////////////

	integral_engine integral_engine_i (
		.clk          (clk),
		.reset        (reset),
		.capture_done (capture_done),
		.src_raddr    (src_raddr),
		.src_rdata    (src_rdata),
		.int_we       (int_we),
		.int_waddr    (int_waddr),
		.int_wdata    (int_wdata),
		.compute_done (compute_done)
	);

	frame_ram #(
		.WIDTH ($bits(integral_t)),
		.DEPTH (FRAME_PIXELS)
	) int_ram_i (
		.clk   (clk),
		.we    (int_we),
		.waddr (int_waddr),
		.wdata (int_wdata),
		.raddr (int_raddr),
		.rdata (int_rdata)
	);

	integral_readout integral_readout_i (
		.clk           (clk),
		.reset         (reset),
		.compute_done  (compute_done),
		.credit_return (credit_return),
		.int_raddr     (int_raddr),
		.int_rdata     (int_rdata),
		.int_out       (int_out),
		.readout_done  (readout_done)
	);

endmodule

// File: integral_image_tb.sv
`timescale 1ns/100ps
`include "frame_defines.svh"

module integral_image_tb import pixel_pkg::*, integral_pkg::*; ();

	localparam int W = `FRAME_WIDTH;
	localparam int H = `FRAME_HEIGHT;
	localparam int N = W * H;
	// slow credit pacing can stretch a frame well past N cycles
	localparam int FRAME_TIMEOUT = N * 64 + 2000;
	localparam rgb332_t UNIFORM_COLOUR = '{red: 3'd5, green: 3'd6, blue: 2'd2};

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        start = 1'b0;
	pixel_beat_t pix_in = '0;
	logic        credit_return = 1'b0;
	int_beat_t   int_out;
	logic        busy;

	// separate generators for pixel draws and sink draws
	logic [15:0] pix_lfsr = 16'd49722;
	logic [15:0] sink_lfsr = 16'd49722;
	// grey values of the driven frame and the expected integral image
	int          grey_model [N];
	int          exp_value [N];
	int          beat_idx = 0;
	int          credits_back = 0;
	// credit pulse of the previous cycle
	bit          credit_seen = 1'b0;
	// beats taken by the sink and not yet paid back
	int          pending = 0;
	bit          expect_active = 1'b0;
	bit          frame_seen = 1'b0;
	bit          long_holds = 1'b0;

	always #4 clk = ~clk;

	integral_image_top integral_image_top_i (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.pix_in        (pix_in),
		.credit_return (credit_return),
		.int_out       (int_out),
		.busy          (busy)
	);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped on error");
	endtask

	////////////////////////////////////////////////////////////
	// random bits
	////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	// one step per bit taken
	function automatic int unsigned pixel_bits(input int nbits);
		int unsigned value;
		value = 0;
		for (int i = 0; i < nbits; i++) begin
			pix_lfsr = lfsr_next(pix_lfsr);
			value = (value << 1) | int'(pix_lfsr[0]);
		end
		return value;
	endfunction

	function automatic int unsigned sink_bits(input int nbits);
		int unsigned value;
		value = 0;
		for (int i = 0; i < nbits; i++) begin
			sink_lfsr = lfsr_next(sink_lfsr);
			value = (value << 1) | int'(sink_lfsr[0]);
		end
		return value;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// flat colour gives grey * (col+1) * (row+1)
	task automatic load_uniform_expected();
		int grey;
		grey = int'(UNIFORM_COLOUR.red) + int'(UNIFORM_COLOUR.green) +
			int'(UNIFORM_COLOUR.blue);
		for (int r = 0; r < H; r++)
			for (int c = 0; c < W; c++)
				exp_value[r * W + c] = grey * (c + 1) * (r + 1);
	endtask

	// inclusion-exclusion over left, up and diagonal neighbours
	task automatic build_expected();
		int idx;
		int left;
		int up;
		int diag;
		for (int r = 0; r < H; r++) begin
			for (int c = 0; c < W; c++) begin
				idx = r * W + c;
				left = (c > 0) ? exp_value[idx - 1] : 0;
				up = (r > 0) ? exp_value[idx - W] : 0;
				diag = (r > 0 && c > 0) ? exp_value[idx - W - 1] : 0;
				exp_value[idx] = grey_model[idx] + left + up - diag;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// random mode adds junk beats before sof, gaps and stray sof flags
	task automatic drive_frame(input bit random_mode);
		int      gap;
		bit      sof_bit;
		rgb332_t px;
		if (random_mode) begin
			repeat (2 + pixel_bits(2)) begin
				@(posedge clk);
				#1;
				pix_in = '{valid: 1'b1, sof: 1'b0, pixel: rgb332_t'(8'(pixel_bits(8)))};
			end
		end
		for (int i = 0; i < N; i++) begin
			px = UNIFORM_COLOUR;
			sof_bit = (i == 0);
			if (random_mode) begin
				gap = (pixel_bits(2) == 0) ? 1 + int'(pixel_bits(2)) : 0;
				repeat (gap) begin
					@(posedge clk);
					#1;
					// sof on an invalid cycle must not start anything
					pix_in = '{valid: 1'b0, sof: 1'(pixel_bits(1)),
						pixel: rgb332_t'(8'(pixel_bits(8)))};
				end
				px = rgb332_t'(8'(pixel_bits(8)));
				if (i > 0) sof_bit = (pixel_bits(4) == 0);
			end
			@(posedge clk);
			#1;
			pix_in = '{valid: 1'b1, sof: sof_bit, pixel: px};
			grey_model[i] = int'(px.red) + int'(px.green) + int'(px.blue);
		end
		@(posedge clk);
		#1;
		pix_in = '0;
	endtask

	// start, pixels, then wait for the final beat
	task automatic run_frame(input bit random_mode, input bit poke_start, input bit slow);
		int cycles;
		if (!random_mode) load_uniform_expected();
		long_holds = slow;
		credits_back = 0;
		credit_seen = 1'b0;
		beat_idx = 0;
		frame_seen = 1'b0;
		expect_active = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		drive_frame(random_mode);
		if (random_mode) build_expected();
		cycles = 0;
		while (!frame_seen) begin
			@(posedge clk);
			#1;
			// stray starts while busy must be ignored
			start = poke_start && busy && (cycles % 29 == 3);
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				abort_run($sformatf("timeout, no final beat after %0d cycles", cycles));
		end
		start = 1'b0;
		assert (!busy)
			else abort_run($sformatf("CHECK FAILED at %0t: busy still high after frame", $time));
	endtask

	////////////////////////////////////////////////////////////
	// sink pays back one credit per beat with random pacing
	////////////////////////////////////////////////////////////

	initial begin
		int hold_left;
		hold_left = 0;
		forever begin
			@(posedge clk);
			#1;
			credit_return = 1'b0;
			if (hold_left > 0) begin
				hold_left--;
			end else if (pending > 0) begin
				// long stall with credits withheld
				if (long_holds && sink_bits(3) == 0) begin
					hold_left = 8 + int'(sink_bits(6));
				end else if (sink_bits(1) == 1) begin
					credit_return = 1'b1;
					pending--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	busy_rises_a: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |=> busy)
		else abort_run($sformatf("CHECK FAILED at %0t: busy did not rise after start", $time));

	busy_holds_a: assert property (@(posedge clk) disable iff (reset)
		(busy && !(int_out.valid && int_out.last)) |=> busy)
		else abort_run($sformatf("CHECK FAILED at %0t: busy fell before the last beat", $time));

	busy_falls_a: assert property (@(posedge clk) disable iff (reset)
		(int_out.valid && int_out.last) |=> !busy)
		else abort_run($sformatf("CHECK FAILED at %0t: busy high after the last beat", $time));

	// pixels alone never arm an idle design
	idle_stays_a: assert property (@(posedge clk) disable iff (reset)
		(!busy && !start) |=> !busy)
		else abort_run($sformatf("CHECK FAILED at %0t: busy rose without start", $time));

	idle_quiet_a: assert property (@(posedge clk) disable iff (reset)
		!busy |-> !int_out.valid)
		else abort_run($sformatf("CHECK FAILED at %0t: beat while idle", $time));

	// outputs settled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (int_out.valid) begin
				assert (expect_active && beat_idx < N)
					else abort_run($sformatf("CHECK FAILED at %0t: unexpected beat, index %0d",
						$time, beat_idx));
				assert (beat_idx < `OUT_CREDITS + credits_back)
					else abort_run($sformatf("CHECK FAILED at %0t: beat %0d sent without credit",
						$time, beat_idx));
				assert (int_out.value == integral_t'(exp_value[beat_idx]))
					else abort_run($sformatf("CHECK FAILED at %0t: beat %0d got %0d, expected %0d",
						$time, beat_idx, int_out.value, exp_value[beat_idx]));
				assert (int_out.last == (beat_idx == N - 1))
					else abort_run($sformatf("CHECK FAILED at %0t: last flag wrong on beat %0d",
						$time, beat_idx));
				if (int_out.last) begin
					expect_active = 1'b0;
					frame_seen = 1'b1;
					pending = 0;
				end else begin
					pending++;
				end
				beat_idx++;
			end
			// a returned credit funds a read from the next cycle on
			if (credit_seen) credits_back++;
			credit_seen = credit_return;
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (!busy && !int_out.valid)
			else abort_run($sformatf("CHECK FAILED at %0t: busy or valid high after reset", $time));
		// full frame with sof while nothing is armed
		drive_frame(1'b1);
		repeat (40) @(posedge clk);
		// flat colour without gaps
		run_frame(1'b0, 1'b0, 1'b0);
		// random pixels with stray starts during compute and readout
		run_frame(1'b1, 1'b1, 1'b0);
		// random pixels with long credit stalls
		run_frame(1'b1, 1'b0, 1'b1);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: integral_image_top.f
+incdir+.
pixel_pkg.sv
integral_pkg.sv
frame_capture.sv
frame_ram.sv
integral_engine.sv
integral_readout.sv
integral_image_top.sv
integral_image_tb.sv

// File: Makefile
# Verilator build and run of the integral image testbench

VERILATOR ?= verilator
TOP       ?= integral_image_tb
FILELIST  ?= integral_image_top.f
BUILD_DIR ?= obj_dir
FRAME_W   ?= 16
FRAME_H   ?= 12
VFLAGS    ?= --binary --timing --assert -Wno-fatal
DEFINES   ?= -DFRAME_WIDTH=$(FRAME_W) -DFRAME_HEIGHT=$(FRAME_H)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR FRAME_W FRAME_H VFLAGS DEFINES"

test:
	$(VERILATOR) $(VFLAGS) $(DEFINES) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
